/* mips_pkg.sv */
package mips_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int SHAMT_W    = 5;
    localparam int ALU_OP_W   = 4;

    localparam logic [XLEN-1:0] RESET_PC = 32'hbfc0_0000;
    localparam logic [XLEN-1:0] PC_STEP  = 32'd4;

    // major opcode, inst[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    // function field of special, inst[5:0]
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a
    } funct_e;

    typedef enum logic [ALU_OP_W-1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_LUI
    } alu_op_e;

    // pc, rs and rt values, immediate, shamt, alu op, a/b selects,
    // load/store strobes, write flag and write address
    localparam int ID_EX_W = 4 * XLEN + SHAMT_W + ALU_OP_W + 2 + 2 + 1 + REG_ADDR_W;

endpackage

/* stage_reg.sv */
module stage_reg #(
    parameter int WIDTH = 32
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             stall,
    input  logic             valid_in,
    input  logic             allow_out,
    output logic             allow_in,
    output logic             valid_out,
    output logic             valid,
    input  logic [WIDTH-1:0] in,
    output logic [WIDTH-1:0] out
);

    // loads only when not stalled and downstream can take the item
    assign allow_in  = ~stall & allow_out;
    // a stalled item stays here and a bubble goes on
    assign valid_out = valid & ~stall;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
        end else if (allow_in) begin
            valid <= valid_in;
        end
    end

    always_ff @(posedge clk) begin
        if (allow_in) begin
            out <= in;
        end
    end

endmodule

/* regfile.sv */
module regfile (
    input  logic                            clk,
    input  logic [mips_pkg::REG_ADDR_W-1:0] raddr1,
    input  logic [mips_pkg::REG_ADDR_W-1:0] raddr2,
    output logic [mips_pkg::XLEN-1:0]       rdata1,
    output logic [mips_pkg::XLEN-1:0]       rdata2,
    input  logic                            wen,
    input  logic [mips_pkg::REG_ADDR_W-1:0] waddr,
    input  logic [mips_pkg::XLEN-1:0]       wdata
);
    import mips_pkg::*;

    logic [XLEN-1:0] regs [2**REG_ADDR_W];

    always_ff @(posedge clk) begin
        if (wen) begin
            regs[waddr] <= wdata;
        end
    end

    // $zero is hardwired, whatever was written to it
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

/* alu.sv */
module alu (
    input  mips_pkg::alu_op_e         op,
    input  logic [mips_pkg::XLEN-1:0] a,
    input  logic [mips_pkg::XLEN-1:0] b,
    output logic [mips_pkg::XLEN-1:0] result
);
    import mips_pkg::*;

    logic slt_bit;

    assign slt_bit = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            ALU_SLT: result = {{(XLEN - 1){1'b0}}, slt_bit};
            // shift amount sits in the low bits of a
            ALU_SLL: result = b << a[SHAMT_W-1:0];
            ALU_SRL: result = b >> a[SHAMT_W-1:0];
            ALU_LUI: result = {b[XLEN/2-1:0], {(XLEN / 2){1'b0}}};
            default: result = a + b;
        endcase
    end

endmodule

/* front_end.sv */
module front_end (
    input  logic                            clk,
    input  logic                            reset,
    output logic                            inst_sram_en,
    output logic [mips_pkg::XLEN-1:0]       inst_sram_addr,
    input  logic [mips_pkg::XLEN-1:0]       inst_sram_rdata,
    input  logic                            allow_in,
    output logic                            id_valid,
    output logic [mips_pkg::ID_EX_W-1:0]    id_payload,
    input  logic                            ex_wen,
    input  logic [mips_pkg::REG_ADDR_W-1:0] ex_waddr,
    input  logic [mips_pkg::XLEN-1:0]       ex_result,
    input  logic                            ex_is_load,
    input  logic                            mem_wen,
    input  logic [mips_pkg::REG_ADDR_W-1:0] mem_waddr,
    input  logic [mips_pkg::XLEN-1:0]       mem_wdata,
    input  logic                            wb_wen,
    input  logic [mips_pkg::REG_ADDR_W-1:0] wb_waddr,
    input  logic [mips_pkg::XLEN-1:0]       wb_wdata,
    output logic                            data_sram_en
);
    import mips_pkg::*;

    localparam int IF_ID_W = 2 * XLEN;

    logic                  start;
    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       next_pc;
    logic [XLEN-1:0]       branch_target;
    logic                  branch_taken;
    logic                  if_id_allow_in;
    logic                  if_id_valid;
    logic [XLEN-1:0]       id_pc;
    logic [XLEN-1:0]       inst;
    opcode_e               opcode;
    funct_e                funct;
    logic [REG_ADDR_W-1:0] rs;
    logic [REG_ADDR_W-1:0] rt;
    logic [REG_ADDR_W-1:0] rd;
    logic [SHAMT_W-1:0]    shamt;
    logic [15:0]           imm_field;
    logic [XLEN-1:0]       imm;
    alu_op_e               alu_op;
    logic                  is_special;
    logic                  is_shift;
    logic                  funct_known;
    logic                  is_load;
    logic                  is_store;
    logic                  is_branch;
    logic                  b_is_imm;
    logic                  imm_zext;
    logic                  rf_wen;
    logic                  use_rs;
    logic                  use_rt;
    logic [REG_ADDR_W-1:0] waddr;
    logic [XLEN-1:0]       rf_rdata1;
    logic [XLEN-1:0]       rf_rdata2;
    logic [XLEN-1:0]       rs_val;
    logic [XLEN-1:0]       rt_val;
    logic                  load_use;

    assign inst_sram_en = 1'b1;

    // pc starts one step early so the first fetch address is RESET_PC
    always_ff @(posedge clk) begin
        if (reset) begin
            start <= 1'b0;
            pc    <= RESET_PC - PC_STEP;
        end else begin
            start <= 1'b1;
            pc    <= next_pc;
        end
    end

    always_comb begin
        if (!if_id_allow_in) begin
            next_pc = pc;
        end else if (branch_taken) begin
            next_pc = branch_target;
        end else begin
            next_pc = pc + PC_STEP;
        end
    end

    assign inst_sram_addr = next_pc;

    stage_reg #(.WIDTH(IF_ID_W)) if_id_reg (
        .clk       (clk),
        .reset     (reset),
        .stall     (load_use),
        .valid_in  (start),
        .allow_out (allow_in),
        .allow_in  (if_id_allow_in),
        .valid_out (id_valid),
        .valid     (if_id_valid),
        .in        ({pc, inst_sram_rdata}),
        .out       ({id_pc, inst})
    );

    assign opcode    = opcode_e'(inst[31:26]);
    assign rs        = inst[25:21];
    assign rt        = inst[20:16];
    assign rd        = inst[15:11];
    assign shamt     = inst[10:6];
    assign imm_field = inst[15:0];
    assign funct     = funct_e'(inst[5:0]);

    always_comb begin
        case (opcode)
            OP_SPECIAL: begin
                case (funct)
                    FN_SLL:  alu_op = ALU_SLL;
                    FN_SRL:  alu_op = ALU_SRL;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    default: alu_op = ALU_ADD;
                endcase
            end
            OP_ANDI: alu_op = ALU_AND;
            OP_ORI:  alu_op = ALU_OR;
            OP_LUI:  alu_op = ALU_LUI;
            default: alu_op = ALU_ADD;
        endcase
    end

    assign is_special  = opcode == OP_SPECIAL;
    assign funct_known = funct inside {FN_SLL, FN_SRL, FN_ADDU, FN_SUBU,
                                       FN_AND, FN_OR, FN_XOR, FN_SLT};
    assign is_shift    = is_special && funct inside {FN_SLL, FN_SRL};
    assign is_load     = opcode == OP_LW;
    assign is_store    = opcode == OP_SW;
    assign is_branch   = opcode inside {OP_BEQ, OP_BNE};
    assign b_is_imm    = opcode inside {OP_ADDIU, OP_ANDI, OP_ORI, OP_LUI, OP_LW, OP_SW};
    assign imm_zext    = opcode inside {OP_ANDI, OP_ORI};
    assign rf_wen      = is_special ? funct_known : (b_is_imm && !is_store);
    assign use_rs      = !is_shift && opcode != OP_LUI;
    assign use_rt      = is_special || is_branch || is_store;
    assign waddr       = is_special ? rd : rt;
    assign imm         = imm_zext ? {16'b0, imm_field} : {{16{imm_field[15]}}, imm_field};

    regfile regfile_inst (
        .clk    (clk),
        .raddr1 (rs),
        .raddr2 (rt),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .wen    (wb_wen),
        .waddr  (wb_waddr),
        .wdata  (wb_wdata)
    );

    // youngest producer first, $zero never forwarded
    function automatic logic [XLEN-1:0] forward_src(
        input logic [REG_ADDR_W-1:0] raddr,
        input logic [XLEN-1:0]       rf_data
    );
        if (raddr == '0) begin
            return rf_data;
        end else if (ex_wen && ex_waddr == raddr) begin
            return ex_result;
        end else if (mem_wen && mem_waddr == raddr) begin
            return mem_wdata;
        end else if (wb_wen && wb_waddr == raddr) begin
            return wb_wdata;
        end
        return rf_data;
    endfunction

    always_comb begin
        rs_val = forward_src(rs, rf_rdata1);
        rt_val = forward_src(rt, rf_rdata2);
    end

    // load in EX has no data yet, hold ID one cycle
    assign load_use = if_id_valid && ex_wen && ex_is_load && ex_waddr != '0
                      && ((use_rs && ex_waddr == rs) || (use_rt && ex_waddr == rt));

    // target relative to the delay slot
    assign branch_target = id_pc + PC_STEP + {{(XLEN - 18){imm_field[15]}}, imm_field, 2'b00};
    assign branch_taken  = if_id_valid
                           && ((opcode == OP_BEQ && rs_val == rt_val)
                            || (opcode == OP_BNE && rs_val != rt_val));

    assign id_payload = {id_pc, rs_val, rt_val, imm, shamt, alu_op, is_shift, b_is_imm,
                         is_load, is_store, rf_wen, waddr};

    // enable tracks the item entering EX
    always_ff @(posedge clk) begin
        if (reset) begin
            data_sram_en <= 1'b0;
        end else if (allow_in) begin
            data_sram_en <= id_valid && (is_load || is_store);
        end
    end

endmodule

/* back_end.sv */
module back_end (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            ex_valid,
    input  logic [mips_pkg::ID_EX_W-1:0]    ex_payload,
    output logic [3:0]                      data_sram_wen,
    output logic [mips_pkg::XLEN-1:0]       data_sram_addr,
    output logic [mips_pkg::XLEN-1:0]       data_sram_wdata,
    input  logic [mips_pkg::XLEN-1:0]       data_sram_rdata,
    output logic                            ex_wen,
    output logic [mips_pkg::REG_ADDR_W-1:0] ex_waddr,
    output logic [mips_pkg::XLEN-1:0]       ex_result,
    output logic                            ex_is_load,
    output logic                            mem_wen,
    output logic [mips_pkg::REG_ADDR_W-1:0] mem_waddr,
    output logic [mips_pkg::XLEN-1:0]       mem_wdata,
    output logic                            wb_wen,
    output logic [mips_pkg::REG_ADDR_W-1:0] wb_waddr,
    output logic [mips_pkg::XLEN-1:0]       wb_wdata,
    output logic [mips_pkg::XLEN-1:0]       debug_wb_pc,
    output logic [3:0]                      debug_wb_rf_wen,
    output logic [mips_pkg::REG_ADDR_W-1:0] debug_wb_rf_wnum,
    output logic [mips_pkg::XLEN-1:0]       debug_wb_rf_wdata
);
    import mips_pkg::*;

    // pc, result, load flag, write flag, write address
    localparam int EX_MEM_W = 2 * XLEN + 2 + REG_ADDR_W;
    // pc, write flag, write address, write data
    localparam int MEM_WB_W = 2 * XLEN + 1 + REG_ADDR_W;

    logic [XLEN-1:0]     ex_pc;
    logic [XLEN-1:0]     ex_rs_val;
    logic [XLEN-1:0]     ex_rt_val;
    logic [XLEN-1:0]     ex_imm;
    logic [SHAMT_W-1:0]  ex_shamt;
    logic [ALU_OP_W-1:0] ex_alu_op;
    logic                ex_a_is_shamt;
    logic                ex_b_is_imm;
    logic                ex_is_store;
    logic                ex_rf_wen;
    logic [XLEN-1:0]     alu_a;
    logic [XLEN-1:0]     alu_b;
    logic                mem_valid;
    logic                mem_valid_out;
    logic [XLEN-1:0]     mem_pc;
    logic [XLEN-1:0]     mem_result;
    logic                mem_is_load;
    logic                mem_rf_wen;
    logic                wb_valid;
    logic [XLEN-1:0]     wb_pc;
    logic                wb_rf_wen;

    assign {ex_pc, ex_rs_val, ex_rt_val, ex_imm, ex_shamt, ex_alu_op, ex_a_is_shamt,
            ex_b_is_imm, ex_is_load, ex_is_store, ex_rf_wen, ex_waddr} = ex_payload;

    assign alu_a = ex_a_is_shamt ? {{(XLEN - SHAMT_W){1'b0}}, ex_shamt} : ex_rs_val;
    assign alu_b = ex_b_is_imm ? ex_imm : ex_rt_val;

    alu alu_inst (
        .op     (alu_op_e'(ex_alu_op)),
        .a      (alu_a),
        .b      (alu_b),
        .result (ex_result)
    );

    assign ex_wen          = ex_valid & ex_rf_wen;
    // word access with the address straight from the alu
    assign data_sram_addr  = ex_result;
    assign data_sram_wdata = ex_rt_val;
    assign data_sram_wen   = {4{ex_valid & ex_is_store}};

    stage_reg #(.WIDTH(EX_MEM_W)) ex_mem_reg (
        .clk       (clk),
        .reset     (reset),
        .stall     (1'b0),
        .valid_in  (ex_valid),
        .allow_out (1'b1),
        .allow_in  (),
        .valid_out (mem_valid_out),
        .valid     (mem_valid),
        .in        ({ex_pc, ex_result, ex_is_load, ex_rf_wen, ex_waddr}),
        .out       ({mem_pc, mem_result, mem_is_load, mem_rf_wen, mem_waddr})
    );

    // load data arrives this cycle
    assign mem_wen   = mem_valid & mem_rf_wen;
    assign mem_wdata = mem_is_load ? data_sram_rdata : mem_result;

    stage_reg #(.WIDTH(MEM_WB_W)) mem_wb_reg (
        .clk       (clk),
        .reset     (reset),
        .stall     (1'b0),
        .valid_in  (mem_valid_out),
        .allow_out (1'b1),
        .allow_in  (),
        .valid_out (),
        .valid     (wb_valid),
        .in        ({mem_pc, mem_rf_wen, mem_waddr, mem_wdata}),
        .out       ({wb_pc, wb_rf_wen, wb_waddr, wb_wdata})
    );

    assign wb_wen            = wb_valid & wb_rf_wen;
    assign debug_wb_pc       = wb_pc;
    assign debug_wb_rf_wen   = {4{wb_wen}};
    assign debug_wb_rf_wnum  = wb_waddr;
    assign debug_wb_rf_wdata = wb_wdata;

endmodule

/* mips_core.sv */
module mips_core (
    input  logic                            clk,
    input  logic                            reset,
    output logic                            inst_sram_en,
    output logic [mips_pkg::XLEN-1:0]       inst_sram_addr,
    input  logic [mips_pkg::XLEN-1:0]       inst_sram_rdata,
    output logic                            data_sram_en,
    output logic [3:0]                      data_sram_wen,
    output logic [mips_pkg::XLEN-1:0]       data_sram_addr,
    output logic [mips_pkg::XLEN-1:0]       data_sram_wdata,
    input  logic [mips_pkg::XLEN-1:0]       data_sram_rdata,
    output logic [mips_pkg::XLEN-1:0]       debug_wb_pc,
    output logic [3:0]                      debug_wb_rf_wen,
    output logic [mips_pkg::REG_ADDR_W-1:0] debug_wb_rf_wnum,
    output logic [mips_pkg::XLEN-1:0]       debug_wb_rf_wdata
);
    import mips_pkg::*;

    logic                  id_valid;
    logic [ID_EX_W-1:0]    id_payload;
    logic                  allow_in;
    logic                  ex_valid;
    logic [ID_EX_W-1:0]    ex_payload;

    // forwarding paths back into decode
    logic                  ex_wen;
    logic [REG_ADDR_W-1:0] ex_waddr;
    logic [XLEN-1:0]       ex_result;
    logic                  ex_is_load;
    logic                  mem_wen;
    logic [REG_ADDR_W-1:0] mem_waddr;
    logic [XLEN-1:0]       mem_wdata;
    logic                  wb_wen;
    logic [REG_ADDR_W-1:0] wb_waddr;
    logic [XLEN-1:0]       wb_wdata;

    // IF and ID, with the register file
    front_end front_end_inst (.*);

    // back end takes an item every cycle
    stage_reg #(.WIDTH(ID_EX_W)) id_ex_reg (
        .clk       (clk),
        .reset     (reset),
        .stall     (1'b0),
        .valid_in  (id_valid),
        .allow_out (1'b1),
        .allow_in  (allow_in),
        .valid_out (ex_valid),
        .valid     (),
        .in        (id_payload),
        .out       (ex_payload)
    );

    // EX, MEM and WB
    back_end back_end_inst (.*);

endmodule

/* tb_trace_checker.sv */
module tb_trace_checker (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] debug_wb_pc,
    input  logic [3:0]  debug_wb_rf_wen,
    input  logic [4:0]  debug_wb_rf_wnum,
    input  logic [31:0] debug_wb_rf_wdata,
    input  logic [3:0]  data_sram_wen,
    input  logic [31:0] data_sram_addr,
    input  logic [31:0] data_sram_wdata,
    output int          pending,
    output int          error_count
);

    logic [31:0] exp_pc [$];
    logic [4:0]  exp_num [$];
    logic [31:0] exp_data [$];
    logic [31:0] st_addr [$];
    logic [31:0] st_data [$];
    int          test_base = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    initial begin
        pending     = 0;
        error_count = 0;
    end

    task automatic clear_expected();
        exp_pc.delete();
        exp_num.delete();
        exp_data.delete();
        st_addr.delete();
        st_data.delete();
        pending = 0;
    endtask

    task automatic add_trace(input logic [31:0] pc, input logic [4:0] num,
                             input logic [31:0] data);
        exp_pc.push_back(pc);
        exp_num.push_back(num);
        exp_data.push_back(data);
        pending++;
    endtask

    task automatic add_store(input logic [31:0] addr, input logic [31:0] data);
        st_addr.push_back(addr);
        st_data.push_back(data);
        pending++;
    endtask

    task automatic note_failure(input string msg);
        $display("error at %0t: %s", $time, msg);
        error_count++;
    endtask

    always @(posedge clk) begin
        if (!reset && debug_wb_rf_wen != 4'h0) begin
            if (exp_pc.size() == 0) begin
                note_failure($sformatf("unexpected write-back at pc %h", debug_wb_pc));
            end else begin
                if (debug_wb_rf_wen != 4'hf || debug_wb_pc != exp_pc[0]
                    || debug_wb_rf_wnum != exp_num[0] || debug_wb_rf_wdata != exp_data[0]) begin
                    $display("mismatch at %0t: trace pc %h r%0d %h wen %h, expected pc %h r%0d %h",
                             $time, debug_wb_pc, debug_wb_rf_wnum, debug_wb_rf_wdata,
                             debug_wb_rf_wen, exp_pc[0], exp_num[0], exp_data[0]);
                    error_count++;
                end
                void'(exp_pc.pop_front());
                void'(exp_num.pop_front());
                void'(exp_data.pop_front());
                pending--;
            end
        end
        // word stores only
        if (!reset && data_sram_wen != 4'h0) begin
            if (st_addr.size() == 0) begin
                note_failure($sformatf("unexpected store to address %h", data_sram_addr));
            end else begin
                if (data_sram_wen != 4'hf || data_sram_addr != st_addr[0]
                    || data_sram_wdata != st_data[0]) begin
                    $display("mismatch at %0t: store wen %h addr %h data %h, expected %h %h",
                             $time, data_sram_wen, data_sram_addr, data_sram_wdata,
                             st_addr[0], st_data[0]);
                    error_count++;
                end
                void'(st_addr.pop_front());
                void'(st_data.pop_front());
                pending--;
            end
        end
    end

    task automatic end_test(input int num, input string name);
        int errs;
        errs = error_count - test_base;
        test_base = error_count;
        tests_run++;
        if (errs == 0) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", num, name, errs);
        end
    endtask

    task automatic summary();
        $display("%0d tests run, %0d ok, %0d failed, %0d errors in total",
                 tests_run, tests_run - tests_failed, tests_failed, error_count);
    endtask

endmodule

/* mips_core_asserts.sv */
module mips_core_asserts (
    input logic        clk,
    input logic        reset,
    input logic        stall,
    input logic [31:0] inst_sram_addr,
    input logic        data_sram_en,
    input logic [3:0]  data_sram_wen,
    input logic [3:0]  debug_wb_rf_wen
);

    // pipeline comes out of reset empty
    wb_quiet_after_reset: assert property (
        @(posedge clk) reset |=> debug_wb_rf_wen == 4'h0
    ) else $error("write-back trace active right after reset");

    wen_needs_en: assert property (
        @(posedge clk) disable iff (reset) data_sram_wen != 4'h0 |-> data_sram_en
    ) else $error("data write strobe without memory enable");

    // refetch of the same word during a load-use stall
    fetch_held_on_stall: assert property (
        @(posedge clk) disable iff (reset) stall |-> $stable(inst_sram_addr)
    ) else $error("fetch address moved during a stall");

endmodule

bind mips_core mips_core_asserts core_asserts (
    .clk             (clk),
    .reset           (reset),
    .stall           (front_end_inst.load_use),
    .inst_sram_addr  (inst_sram_addr),
    .data_sram_en    (data_sram_en),
    .data_sram_wen   (data_sram_wen),
    .debug_wb_rf_wen (debug_wb_rf_wen)
);

/* tb_mips_core.sv */
module tb_mips_core;
    import mips_pkg::*;

    localparam int NUM_TESTS = 5;
    localparam int MAX_PROG  = 16;
    localparam int MAX_TRACE = 16;
    localparam int IMEM_WORDS = 256;
    localparam int DMEM_WORDS = 256;
    localparam int TIMEOUT_CYCLES = 200;

    logic                  clk;
    logic                  reset;
    logic                  inst_sram_en;
    logic [XLEN-1:0]       inst_sram_addr;
    logic [XLEN-1:0]       inst_sram_rdata;
    logic                  data_sram_en;
    logic [3:0]            data_sram_wen;
    logic [XLEN-1:0]       data_sram_addr;
    logic [XLEN-1:0]       data_sram_wdata;
    logic [XLEN-1:0]       data_sram_rdata;
    logic [XLEN-1:0]       debug_wb_pc;
    logic [3:0]            debug_wb_rf_wen;
    logic [REG_ADDR_W-1:0] debug_wb_rf_wnum;
    logic [XLEN-1:0]       debug_wb_rf_wdata;
    int                    pending;
    int                    error_count;

    // program and expected trace per test
    string           test_name  [NUM_TESTS];
    logic [XLEN-1:0] prog       [NUM_TESTS][MAX_PROG];
    int              prog_len   [NUM_TESTS];
    int              exp_idx    [NUM_TESTS][MAX_TRACE];
    logic [4:0]      exp_num    [NUM_TESTS][MAX_TRACE];
    logic [XLEN-1:0] exp_data   [NUM_TESTS][MAX_TRACE];
    int              exp_len    [NUM_TESTS];
    logic            has_store  [NUM_TESTS];
    logic [XLEN-1:0] store_addr [NUM_TESTS];
    logic [XLEN-1:0] store_data [NUM_TESTS];

    logic [XLEN-1:0] imem [IMEM_WORDS];
    logic [XLEN-1:0] dmem [DMEM_WORDS];
    logic            i_en_q;
    logic [XLEN-1:0] i_addr_q;
    logic            d_en_q;
    logic [3:0]      d_wen_q;
    logic [XLEN-1:0] d_addr_q;
    logic [XLEN-1:0] d_wdata_q;

    mips_core mips_core_inst (.*);

    tb_trace_checker trace_check (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // undefined opcode that writes no register or memory
    function automatic logic [XLEN-1:0] fill_inst(input logic [XLEN-1:0] addr);
        return {6'h3f, addr[27:2] ^ {20'b0, addr[31:28], addr[1:0]}};
    endfunction

    function automatic logic [XLEN-1:0] rtype(input funct_e fn, input logic [4:0] rd,
                                              input logic [4:0] rs, input logic [4:0] rt);
        return {OP_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [XLEN-1:0] shift_inst(input funct_e fn, input logic [4:0] rd,
                                                   input logic [4:0] rt, input logic [4:0] sa);
        return {OP_SPECIAL, 5'd0, rt, rd, sa, fn};
    endfunction

    function automatic logic [XLEN-1:0] itype(input opcode_e op, input logic [4:0] rt,
                                              input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic add_inst(input int t, input logic [XLEN-1:0] word);
        prog[t][prog_len[t]] = word;
        prog_len[t]++;
    endtask

    // instruction whose write-back of num with data shows up in the trace
    task automatic add_inst_wb(input int t, input logic [XLEN-1:0] word, input logic [4:0] num,
                               input logic [XLEN-1:0] data);
        exp_idx[t][exp_len[t]]  = prog_len[t];
        exp_num[t][exp_len[t]]  = num;
        exp_data[t][exp_len[t]] = data;
        exp_len[t]++;
        add_inst(t, word);
    endtask

    task automatic build_table();
        for (int t = 0; t < NUM_TESTS; t++) begin
            prog_len[t]  = 0;
            exp_len[t]   = 0;
            has_store[t] = 1'b0;
        end

        test_name[0] = "alu_ops";
        add_inst_wb(0, itype(OP_LUI, 1, 0, 16'h1234), 1, 32'h1234_0000);
        add_inst_wb(0, itype(OP_ORI, 2, 0, 16'h5678), 2, 32'h0000_5678);
        add_inst_wb(0, itype(OP_ADDIU, 3, 0, 16'hffff), 3, 32'hffff_ffff);
        add_inst_wb(0, rtype(FN_ADDU, 4, 1, 2), 4, 32'h1234_5678);
        add_inst_wb(0, rtype(FN_SUBU, 5, 2, 3), 5, 32'h0000_5679);
        add_inst_wb(0, rtype(FN_SLT, 6, 3, 2), 6, 32'h1);
        add_inst_wb(0, rtype(FN_SLT, 7, 2, 3), 7, 32'h0);
        add_inst_wb(0, rtype(FN_AND, 8, 4, 3), 8, 32'h1234_5678);
        add_inst_wb(0, rtype(FN_XOR, 9, 4, 1), 9, 32'h0000_5678);
        add_inst_wb(0, shift_inst(FN_SLL, 10, 2, 4), 10, 32'h0005_6780);
        add_inst_wb(0, shift_inst(FN_SRL, 11, 3, 28), 11, 32'hf);
        add_inst_wb(0, itype(OP_ANDI, 12, 3, 16'h8001), 12, 32'h0000_8001);
        add_inst_wb(0, rtype(FN_OR, 13, 1, 2), 13, 32'h1234_5678);

        test_name[1] = "forwarding";
        add_inst_wb(1, itype(OP_ADDIU, 1, 0, 16'd5), 1, 32'h5);
        add_inst_wb(1, itype(OP_ADDIU, 2, 1, 16'd3), 2, 32'h8);
        add_inst_wb(1, rtype(FN_ADDU, 3, 1, 2), 3, 32'hd);
        add_inst_wb(1, rtype(FN_ADDU, 4, 1, 3), 4, 32'h12);
        add_inst_wb(1, rtype(FN_SUBU, 5, 4, 2), 5, 32'ha);

        test_name[2] = "load_store";
        add_inst_wb(2, itype(OP_ADDIU, 1, 0, 16'h0040), 1, 32'h40);
        add_inst_wb(2, itype(OP_LUI, 2, 0, 16'hcafe), 2, 32'hcafe_0000);
        add_inst_wb(2, itype(OP_ORI, 2, 2, 16'hbeef), 2, 32'hcafe_beef);
        add_inst(2, itype(OP_SW, 2, 1, 16'd8));
        add_inst_wb(2, itype(OP_LW, 3, 1, 16'd8), 3, 32'hcafe_beef);
        // load-use stall on $3
        add_inst_wb(2, itype(OP_ADDIU, 4, 3, 16'd1), 4, 32'hcafe_bef0);
        add_inst_wb(2, rtype(FN_ADDU, 5, 4, 3), 5, 32'h95fd_7ddf);
        has_store[2]  = 1'b1;
        store_addr[2] = 32'h48;
        store_data[2] = 32'hcafe_beef;

        test_name[3] = "branches";
        add_inst_wb(3, itype(OP_ADDIU, 1, 0, 16'd1), 1, 32'h1);
        add_inst(3, itype(OP_BEQ, 0, 1, 16'd2));
        add_inst_wb(3, itype(OP_ADDIU, 2, 0, 16'd2), 2, 32'h2);
        add_inst_wb(3, itype(OP_ADDIU, 3, 0, 16'd3), 3, 32'h3);
        add_inst(3, itype(OP_BNE, 0, 1, 16'd2));
        add_inst_wb(3, itype(OP_ADDIU, 4, 0, 16'd4), 4, 32'h4);
        add_inst(3, itype(OP_ADDIU, 5, 0, 16'd5));
        add_inst(3, itype(OP_BEQ, 0, 0, 16'd2));
        add_inst_wb(3, itype(OP_ADDIU, 6, 0, 16'd6), 6, 32'h6);
        add_inst(3, itype(OP_ADDIU, 7, 0, 16'd7));
        add_inst(3, itype(OP_BNE, 1, 1, 16'd2));
        add_inst_wb(3, itype(OP_ADDIU, 8, 0, 16'd8), 8, 32'h8);
        add_inst_wb(3, itype(OP_ADDIU, 9, 0, 16'd9), 9, 32'h9);

        test_name[4] = "reg_zero";
        add_inst_wb(4, itype(OP_ADDIU, 0, 0, 16'h0055), 0, 32'h55);
        add_inst_wb(4, rtype(FN_ADDU, 1, 0, 0), 1, 32'h0);
        add_inst_wb(4, itype(OP_ORI, 2, 0, 16'h0007), 2, 32'h7);
        add_inst_wb(4, rtype(FN_ADDU, 3, 2, 0), 3, 32'h7);
        // $0 now read back from the register file
        add_inst_wb(4, rtype(FN_ADDU, 4, 0, 2), 4, 32'h7);
    endtask

    // both memories answer one cycle after the address
    always @(posedge clk) begin
        i_en_q    = inst_sram_en;
        i_addr_q  = inst_sram_addr;
        d_en_q    = data_sram_en;
        d_wen_q   = data_sram_wen;
        d_addr_q  = data_sram_addr;
        d_wdata_q = data_sram_wdata;
        #1;
        if (i_en_q) begin
            if ((i_addr_q - RESET_PC) < IMEM_WORDS * 4) begin
                inst_sram_rdata = imem[(i_addr_q - RESET_PC) >> 2];
            end else begin
                inst_sram_rdata = fill_inst(i_addr_q);
            end
        end
        if (d_en_q) begin
            if (d_wen_q == 4'hf) begin
                dmem[d_addr_q[9:2]] = d_wdata_q;
            end
            data_sram_rdata = dmem[d_addr_q[9:2]];
        end
    end

    task automatic run_test(input int t);
        int cycles;
        @(posedge clk);
        #1 reset = 1'b1;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = fill_inst(RESET_PC + 4 * i);
        end
        for (int i = 0; i < prog_len[t]; i++) begin
            imem[i] = prog[t][i];
        end
        trace_check.clear_expected();
        for (int i = 0; i < exp_len[t]; i++) begin
            trace_check.add_trace(RESET_PC + 4 * exp_idx[t][i], exp_num[t][i], exp_data[t][i]);
        end
        if (has_store[t]) begin
            trace_check.add_store(store_addr[t], store_data[t]);
        end
        repeat (2) @(posedge clk);
        #1 reset = 1'b0;
        cycles = 0;
        while (pending != 0 && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (pending != 0) begin
            trace_check.note_failure($sformatf("test %s timed out with %0d entries missing",
                                               test_name[t], pending));
        end
        trace_check.end_test(t, test_name[t]);
    endtask

    initial begin
        reset           = 1'b1;
        inst_sram_rdata = '0;
        data_sram_rdata = '0;
        build_table();
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = (i * 4) ^ 32'h5a5a_0000;
        end
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        trace_check.summary();
        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* sim.f */
mips_pkg.sv
stage_reg.sv
regfile.sv
alu.sv
front_end.sv
back_end.sv
mips_core.sv
tb_trace_checker.sv
mips_core_asserts.sv
tb_mips_core.sv

/* Bender.yml */
package:
  name: mips_core

sources:
  - mips_pkg.sv
  - stage_reg.sv
  - regfile.sv
  - alu.sv
  - front_end.sv
  - back_end.sv
  - mips_core.sv
  - target: test
    files:
      - tb_trace_checker.sv
      - mips_core_asserts.sv
      - tb_mips_core.sv
